// File: design/dac_regmap_pkg.sv
`default_nettype none

package dac_regmap_pkg;

  // ************************************************************
  // processor bus widths
  // ************************************************************

  localparam int unsigned UP_ADDR_W = 14;
  localparam int unsigned UP_DATA_W = 32;

  // word address and data word
  typedef logic [UP_ADDR_W-1:0] up_addr_t;
  typedef logic [UP_DATA_W-1:0] up_data_t;

  // page number sits in address bits 13..8
  localparam logic [5:0] PAGE_COMMON  = 6'h00;
  localparam logic [5:0] PAGE_CHANNEL = 6'h01;

  // ************************************************************
  // register offsets within a page
  // ************************************************************

  // common page
  localparam logic [7:0] REG_VERSION  = 8'h00;
  localparam logic [7:0] REG_ID       = 8'h01;
  localparam logic [7:0] REG_SCRATCH  = 8'h02;
  localparam logic [7:0] REG_CONTROL  = 8'h10;
  localparam logic [7:0] REG_FORMAT   = 8'h11;
  localparam logic [7:0] REG_STATUS   = 8'h12;

  // channel page
  localparam logic [7:0] REG_SOURCE   = 8'h00;
  localparam logic [7:0] REG_CONSTANT = 8'h01;
  localparam logic [7:0] REG_STEP     = 8'h02;

  // major.minor.patch as 16.8.8
  localparam up_data_t CORE_VERSION = 32'h0001_0200;

endpackage

`default_nettype wire

// File: design/dac_sample_pkg.sv
`default_nettype none

package dac_sample_pkg;

  // ************************************************************
  // sample datapath types
  // ************************************************************

  // one converter sample
  localparam int unsigned SAMPLE_W = 16;

  typedef logic [SAMPLE_W-1:0] sample_t;

  // ramp increment between adjacent lanes
  typedef logic [SAMPLE_W-1:0] step_t;

  // channel source select
  typedef logic [1:0] source_t;

  // dma stream from the host side
  localparam source_t SRC_DMA   = 2'd0;
  // fixed value from the channel page
  localparam source_t SRC_CONST = 2'd1;
  // ramp from the pattern generator
  localparam source_t SRC_RAMP  = 2'd2;

  // code 3 is left unassigned, datapath falls back to dma

endpackage

`default_nettype wire

// File: design/dac_common_regs.sv
`default_nettype none

module dac_common_regs import dac_regmap_pkg::*; #(
  parameter up_data_t ID = 32'h0
) (
  input  wire       up_clk,
  input  wire       up_rstn,
  input  wire       up_wreq,
  input  up_addr_t  up_waddr,
  input  up_data_t  up_wdata,
  output logic      up_wack,
  input  wire       up_rreq,
  input  up_addr_t  up_raddr,
  output up_data_t  up_rdata,
  output logic      up_rack,
  output logic      dac_rst,
  output logic      dac_enable,
  output logic      dac_sync,
  output logic      dac_format,
  input  wire       dac_status,
  input  wire       dac_dovf,
  input  wire       dac_dunf
);

  // page decode
  logic     wr_en;
  logic     rd_en;
  // register contents
  up_data_t scratch;
  logic     rst_release;
  logic     status_ovf;
  logic     status_unf;

  assign wr_en = up_wreq && (up_waddr[13:8] == PAGE_COMMON);
  assign rd_en = up_rreq && (up_raddr[13:8] == PAGE_COMMON);

  // dac held in reset until software releases it
  assign dac_rst = ~rst_release;

  // ************************************************************
  // write side
  // ************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack     <= 1'b0;
      scratch     <= '0;
      rst_release <= 1'b0;
      dac_enable  <= 1'b0;
      dac_sync    <= 1'b0;
      dac_format  <= 1'b0;
    end else begin
      up_wack  <= wr_en;
      // sync only lives for one cycle
      dac_sync <= wr_en && (up_waddr[7:0] == REG_CONTROL) && up_wdata[1];
      if (wr_en && (up_waddr[7:0] == REG_SCRATCH)) begin
        scratch <= up_wdata;
      end
      if (wr_en && (up_waddr[7:0] == REG_CONTROL)) begin
        rst_release <= up_wdata[0];
        dac_enable  <= up_wdata[2];
      end
      if (wr_en && (up_waddr[7:0] == REG_FORMAT)) begin
        dac_format <= up_wdata[0];
      end
    end
  end

  // sticky flags, a new event wins over a same-cycle clear
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      status_ovf <= 1'b0;
      status_unf <= 1'b0;
    end else begin
      if (dac_dovf) begin
        status_ovf <= 1'b1;
      end else if (wr_en && (up_waddr[7:0] == REG_STATUS) && up_wdata[0]) begin
        status_ovf <= 1'b0;
      end
      if (dac_dunf) begin
        status_unf <= 1'b1;
      end else if (wr_en && (up_waddr[7:0] == REG_STATUS) && up_wdata[1]) begin
        status_unf <= 1'b0;
      end
    end
  end

  // ************************************************************
  // read side
  // ************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack <= rd_en;
      if (rd_en) begin
        case (up_raddr[7:0])
          REG_VERSION: up_rdata <= CORE_VERSION;
          REG_ID:      up_rdata <= ID;
          REG_SCRATCH: up_rdata <= scratch;
          // sync bit always reads as 0
          REG_CONTROL: up_rdata <= {29'd0, dac_enable, 1'b0, rst_release};
          REG_FORMAT:  up_rdata <= {31'd0, dac_format};
          REG_STATUS:  up_rdata <= {29'd0, dac_status, status_unf, status_ovf};
          default:     up_rdata <= '0;
        endcase
      end else begin
        up_rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dac_channel_regs.sv
`default_nettype none

module dac_channel_regs import dac_regmap_pkg::*, dac_sample_pkg::*; (
  input  wire       up_clk,
  input  wire       up_rstn,
  input  wire       up_wreq,
  input  up_addr_t  up_waddr,
  input  up_data_t  up_wdata,
  output logic      up_wack,
  input  wire       up_rreq,
  input  up_addr_t  up_raddr,
  output up_data_t  up_rdata,
  output logic      up_rack,
  output source_t   dac_source,
  output sample_t   dac_constant,
  output step_t     dac_step
);

  // page decode
  logic wr_en;
  logic rd_en;

  assign wr_en = up_wreq && (up_waddr[13:8] == PAGE_CHANNEL);
  assign rd_en = up_rreq && (up_raddr[13:8] == PAGE_CHANNEL);

  // ************************************************************
  // write side
  // ************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack      <= 1'b0;
      dac_source   <= SRC_DMA;
      dac_constant <= '0;
      // unit step gives a plain counting ramp
      dac_step     <= step_t'(1);
    end else begin
      up_wack <= wr_en;
      if (wr_en) begin
        case (up_waddr[7:0])
          // code 3 kept as written
          REG_SOURCE:   dac_source   <= up_wdata[1:0];
          REG_CONSTANT: dac_constant <= up_wdata[SAMPLE_W-1:0];
          REG_STEP:     dac_step     <= up_wdata[SAMPLE_W-1:0];
          default: begin
            // other offsets take the ack only
          end
        endcase
      end
    end
  end

  // ************************************************************
  // read side
  // ************************************************************

  // data only valid alongside the ack
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack <= rd_en;
      if (rd_en) begin
        case (up_raddr[7:0])
          REG_SOURCE:   up_rdata <= {30'd0, dac_source};
          REG_CONSTANT: up_rdata <= {16'd0, dac_constant};
          REG_STEP:     up_rdata <= {16'd0, dac_step};
          default:      up_rdata <= '0;
        endcase
      end else begin
        up_rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dac_pattern_gen.sv
`default_nettype none

module dac_pattern_gen import dac_sample_pkg::*; #(
  parameter int unsigned LANES = 16
) (
  input  wire                         up_clk,
  input  wire                         dac_rst,
  input  wire                         dac_sync,
  input  step_t                       dac_step,
  output logic [LANES*SAMPLE_W-1:0]   pattern_data
);

  // ramp value of lane 0 in the current word
  sample_t base;
  // distance from one word to the next
  sample_t word_step;

  // everything wraps modulo 2^16
  assign word_step = sample_t'(LANES) * dac_step;

  // ************************************************************
  // base counter
  // ************************************************************

  // sync or reset puts the next word back at 0
  always_ff @(posedge up_clk) begin
    if (dac_rst || dac_sync) begin
      base <= '0;
    end else begin
      base <= base + word_step;
    end
  end

  // ************************************************************
  // lane fan-out
  // ************************************************************

  // lane i sits i steps above lane 0
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign pattern_data[i*SAMPLE_W +: SAMPLE_W] = base + sample_t'(i) * dac_step;
  end

  // lanes are combinational from base
  // so a word tracks a step change right away

endmodule

`default_nettype wire

// File: design/dac_channel.sv
`default_nettype none

module dac_channel import dac_sample_pkg::*; #(
  parameter int unsigned LANES = 16
) (
  input  wire                         up_clk,
  input  wire                         dac_rst,
  input  wire                         dac_enable,
  input  source_t                     dac_source,
  input  sample_t                     dac_constant,
  input  wire                         dac_format,
  input  wire  [LANES*SAMPLE_W-1:0]   dma_data,
  input  wire  [LANES*SAMPLE_W-1:0]   pattern_data,
  output logic [LANES*SAMPLE_W-1:0]   dac_data
);

  // selected and formatted word, before the output register
  logic [LANES*SAMPLE_W-1:0] data_next;

  // ************************************************************
  // per-lane select and format
  // ************************************************************

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    sample_t sel_s;

    // unknown source code behaves as dma
    always_comb begin
      case (dac_source)
        SRC_CONST: sel_s = dac_constant;
        SRC_RAMP:  sel_s = pattern_data[i*SAMPLE_W +: SAMPLE_W];
        default:   sel_s = dma_data[i*SAMPLE_W +: SAMPLE_W];
      endcase
    end

    // offset binary is two's complement with the sign bit flipped
    assign data_next[i*SAMPLE_W +: SAMPLE_W] =
      {sel_s[SAMPLE_W-1] ^ dac_format, sel_s[SAMPLE_W-2:0]};
  end

  // ************************************************************
  // output register
  // ************************************************************

  // all zeros while the dac sits in reset or is disabled
  always_ff @(posedge up_clk) begin
    if (dac_rst || !dac_enable) begin
      dac_data <= '0;
    end else begin
      dac_data <= data_next;
    end
  end

endmodule

`default_nettype wire

// File: design/dac_core.sv
`default_nettype none

module dac_core import dac_regmap_pkg::*, dac_sample_pkg::*; #(
  parameter up_data_t    ID    = 32'h0,
  parameter int unsigned LANES = 16
) (
  // processor interface
  input  wire                         up_clk,
  input  wire                         up_rstn,
  input  wire                         up_wreq,
  input  up_addr_t                    up_waddr,
  input  up_data_t                    up_wdata,
  output logic                        up_wack,
  input  wire                         up_rreq,
  input  up_addr_t                    up_raddr,
  output up_data_t                    up_rdata,
  output logic                        up_rack,
  // dma interface
  input  wire  [LANES*SAMPLE_W-1:0]   dac_ddata,
  input  wire                         dac_dovf,
  input  wire                         dac_dunf,
  output logic                        dac_enable,
  // dac interface
  output logic                        dac_rst,
  output logic [LANES*SAMPLE_W-1:0]   dac_data,
  input  wire                         dac_status
);

  // control from the common page
  logic                      dac_sync_s;
  logic                      dac_format_s;
  // control from the channel page
  source_t                   dac_source_s;
  sample_t                   dac_constant_s;
  step_t                     dac_step_s;
  logic [LANES*SAMPLE_W-1:0] pattern_data_s;
  // per-page bus responses
  up_data_t                  up_rdata_c_s;
  up_data_t                  up_rdata_ch_s;
  logic                      up_wack_c_s;
  logic                      up_wack_ch_s;
  logic                      up_rack_c_s;
  logic                      up_rack_ch_s;

  // ************************************************************
  // bus response merge
  // ************************************************************

  // idle pages drive zero so an or is enough
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack  <= up_wack_c_s | up_wack_ch_s;
      up_rack  <= up_rack_c_s | up_rack_ch_s;
      up_rdata <= up_rdata_c_s | up_rdata_ch_s;
    end
  end

  // common page
  dac_common_regs #(.ID(ID)) i_common_regs (
    .up_clk (up_clk), .up_rstn (up_rstn),
    .up_wreq (up_wreq), .up_waddr (up_waddr), .up_wdata (up_wdata), .up_wack (up_wack_c_s),
    .up_rreq (up_rreq), .up_raddr (up_raddr), .up_rdata (up_rdata_c_s), .up_rack (up_rack_c_s),
    .dac_rst (dac_rst), .dac_enable (dac_enable), .dac_sync (dac_sync_s),
    .dac_format (dac_format_s), .dac_status (dac_status),
    .dac_dovf (dac_dovf), .dac_dunf (dac_dunf));

  // channel page
  dac_channel_regs i_channel_regs (
    .up_clk (up_clk), .up_rstn (up_rstn),
    .up_wreq (up_wreq), .up_waddr (up_waddr), .up_wdata (up_wdata), .up_wack (up_wack_ch_s),
    .up_rreq (up_rreq), .up_raddr (up_raddr), .up_rdata (up_rdata_ch_s), .up_rack (up_rack_ch_s),
    .dac_source (dac_source_s), .dac_constant (dac_constant_s), .dac_step (dac_step_s));

  // ramp source
  dac_pattern_gen #(.LANES(LANES)) i_pattern_gen (
    .up_clk (up_clk), .dac_rst (dac_rst), .dac_sync (dac_sync_s),
    .dac_step (dac_step_s), .pattern_data (pattern_data_s));

  // datapath
  dac_channel #(.LANES(LANES)) i_channel (
    .up_clk (up_clk), .dac_rst (dac_rst), .dac_enable (dac_enable),
    .dac_source (dac_source_s), .dac_constant (dac_constant_s), .dac_format (dac_format_s),
    .dma_data (dac_ddata), .pattern_data (pattern_data_s), .dac_data (dac_data));

endmodule

`default_nettype wire

// File: verification/dac_core_tb_ref.svh
`ifndef DAC_CORE_TB_REF_SVH
`define DAC_CORE_TB_REF_SVH

// ************************************************************
// expected values, LANES comes from the testbench
// ************************************************************

// one output lane from source, format and ramp position
function automatic sample_t exp_sample(
  input source_t source,
  input sample_t const_val,
  input step_t   step,
  input int      lane,
  input int      since_sync,
  input sample_t dma,
  input logic    format
);
  sample_t raw;
  longint  ramp;
  // word k starts at k*LANES*step, lane i adds i*step
  ramp = longint'(since_sync) * longint'(LANES) * longint'(step)
       + longint'(lane) * longint'(step);
  case (source)
    SRC_CONST: raw = const_val;
    SRC_RAMP:  raw = sample_t'(ramp);
    // code 3 falls back to dma
    default:   raw = dma;
  endcase
  // offset binary flips the sign bit
  if (format) begin
    raw[SAMPLE_W-1] = ~raw[SAMPLE_W-1];
  end
  return raw;
endfunction

// status read-back: sticky ovf, sticky unf, live status
function automatic up_data_t exp_status(input logic ovf, input logic unf, input logic status);
  return {29'd0, status, unf, ovf};
endfunction

// control read-back, sync always reads 0
function automatic up_data_t exp_control(input logic release_rst, input logic enable);
  return {29'd0, enable, 1'b0, release_rst};
endfunction

`endif

// File: verification/dac_core_tb.sv
`default_nettype none

module dac_core_tb
  import dac_regmap_pkg::*, dac_sample_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LANES = 4;
  localparam int unsigned DATA_W = LANES * SAMPLE_W;
  localparam int BUS_TIMEOUT = 16;

  logic              up_clk = 1'b0;
  logic              up_rstn, up_wreq, up_rreq, up_wack, up_rack;
  up_addr_t          up_waddr, up_raddr;
  up_data_t          up_wdata, up_rdata;
  logic [DATA_W-1:0] dac_ddata, dac_data;
  logic              dac_dovf, dac_dunf, dac_status, dac_rst, dac_enable;

  int seed = 32'h820f;
  int errors = 0;
  int checks = 0;

  // register state as the DUT should hold it in the current cycle
  logic    m_valid = 1'b0;
  logic    m_release = 1'b0;
  logic    m_enable = 1'b0;
  logic    m_sync = 1'b0;
  logic    m_format = 1'b0;
  source_t m_source = SRC_DMA;
  sample_t m_constant = '0;
  step_t   m_step = step_t'(1);
  int      m_ramp_k = 0;
  // word the DUT registers at the last rising edge
  logic              exp_valid = 1'b0;
  logic [DATA_W-1:0] exp_word = '0;

  `include "dac_core_tb_ref.svh"

  dac_core #(
    .ID    (32'h0000_005A),
    .LANES (LANES)
  ) dut_i (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_wack    (up_wack),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .up_rdata   (up_rdata),
    .up_rack    (up_rack),
    .dac_ddata  (dac_ddata),
    .dac_dovf   (dac_dovf),
    .dac_dunf   (dac_dunf),
    .dac_enable (dac_enable),
    .dac_rst    (dac_rst),
    .dac_data   (dac_data),
    .dac_status (dac_status)
  );

  always #4 up_clk = ~up_clk;

  task automatic compare_value(input string name, input up_data_t got, input up_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic compare_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] dac_data: expected %h, got %h", exp, got);
    end
  endtask

  // ************************************************************
  // bus tasks called just after a falling edge
  // ************************************************************

  task automatic write_reg(input up_addr_t addr, input up_data_t data);
    int cycles;
    up_wreq = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(negedge up_clk);
    up_wreq = 1'b0;
    cycles = 1;
    while (!up_wack && cycles < BUS_TIMEOUT) begin
      @(negedge up_clk);
      cycles++;
    end
    if (!up_wack) begin
      errors++;
      $display("write to address %h got no ack within %0d cycles", addr, BUS_TIMEOUT);
    end else if (cycles != 2) begin
      errors++;
      $display("write ack came %0d cycles after the request instead of 2", cycles);
    end
  endtask

  task automatic read_reg(input up_addr_t addr, output up_data_t data);
    int cycles;
    up_rreq = 1'b1;
    up_raddr = addr;
    @(negedge up_clk);
    up_rreq = 1'b0;
    cycles = 1;
    while (!up_rack && cycles < BUS_TIMEOUT) begin
      @(negedge up_clk);
      cycles++;
    end
    data = up_rdata;
    if (!up_rack) begin
      errors++;
      $display("read from address %h got no ack within %0d cycles", addr, BUS_TIMEOUT);
    end else if (cycles != 2) begin
      errors++;
      $display("read ack came %0d cycles after the request instead of 2", cycles);
    end
  endtask

  task automatic expect_reg(input string name, input up_addr_t addr, input up_data_t exp);
    up_data_t got;
    read_reg(addr, got);
    compare_value(name, got, exp);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge up_clk);
  endtask

  // ************************************************************
  // reference model and compare
  // ************************************************************

  always @(posedge up_clk) begin
    exp_valid = m_valid;
    for (int i = 0; i < LANES; i++) begin
      if (m_release && m_enable) begin
        exp_word[i*SAMPLE_W +: SAMPLE_W] = exp_sample(m_source, m_constant, m_step, i,
          m_ramp_k, dac_ddata[i*SAMPLE_W +: SAMPLE_W], m_format);
      end else begin
        exp_word[i*SAMPLE_W +: SAMPLE_W] = '0;
      end
    end
    // ramp restarts on sync and while the dac sits in reset
    if (!m_release || m_sync) begin
      m_ramp_k = 0;
    end else begin
      m_ramp_k++;
    end
    m_sync = 1'b0;
    if (!up_rstn) begin
      m_valid = 1'b1;
      m_release = 1'b0;
      m_enable = 1'b0;
      m_format = 1'b0;
      m_source = SRC_DMA;
      m_constant = '0;
      m_step = step_t'(1);
    end else if (up_wreq) begin
      case (up_waddr)
        {PAGE_COMMON, REG_CONTROL}: begin
          m_release = up_wdata[0];
          m_sync = up_wdata[1];
          m_enable = up_wdata[2];
        end
        {PAGE_COMMON, REG_FORMAT}:    m_format = up_wdata[0];
        {PAGE_CHANNEL, REG_SOURCE}:   m_source = up_wdata[1:0];
        {PAGE_CHANNEL, REG_CONSTANT}: m_constant = up_wdata[SAMPLE_W-1:0];
        {PAGE_CHANNEL, REG_STEP}:     m_step = up_wdata[SAMPLE_W-1:0];
        default: ;
      endcase
    end
  end

  // outputs are stable mid-cycle
  always @(negedge up_clk) begin
    if (exp_valid) begin
      compare_word(dac_data, exp_word);
    end
    if (m_valid) begin
      compare_value("dac_rst", up_data_t'(dac_rst), up_data_t'(!m_release));
      compare_value("dac_enable", up_data_t'(dac_enable), up_data_t'(m_enable));
    end
  end

  // fresh dma word every cycle
  always @(negedge up_clk) begin
    for (int i = 0; i < LANES; i++) begin
      dac_ddata[i*SAMPLE_W +: SAMPLE_W] = sample_t'($random(seed));
    end
  end

  // ************************************************************
  // stimulus
  // ************************************************************

  initial begin
    up_data_t scratch_val;
    sample_t  const_val;
    step_t    step_val;
    logic     ovf_seen;
    logic     unf_seen;
    up_rstn = 1'b0;
    up_wreq = 1'b0;
    up_rreq = 1'b0;
    up_waddr = '0;
    up_raddr = '0;
    up_wdata = '0;
    dac_ddata = '0;
    dac_dovf = 1'b0;
    dac_dunf = 1'b0;
    dac_status = 1'b0;
    repeat (4) @(negedge up_clk);
    up_rstn = 1'b1;

    // identity, scratch and reset values
    compare_value("dac_rst", up_data_t'(dac_rst), 32'd1);
    compare_word(dac_data, '0);
    expect_reg("REG_VERSION", {PAGE_COMMON, REG_VERSION}, CORE_VERSION);
    expect_reg("REG_ID", {PAGE_COMMON, REG_ID}, 32'h0000_005A);
    scratch_val = $random(seed);
    write_reg({PAGE_COMMON, REG_SCRATCH}, scratch_val);
    expect_reg("REG_SCRATCH", {PAGE_COMMON, REG_SCRATCH}, scratch_val);
    expect_reg("REG_CONTROL", {PAGE_COMMON, REG_CONTROL}, exp_control(1'b0, 1'b0));
    expect_reg("REG_SOURCE", {PAGE_CHANNEL, REG_SOURCE}, {30'd0, SRC_DMA});
    expect_reg("REG_STEP", {PAGE_CHANNEL, REG_STEP}, 32'd1);

    // dma path in both formats
    write_reg({PAGE_COMMON, REG_CONTROL}, 32'h5);
    expect_reg("REG_CONTROL", {PAGE_COMMON, REG_CONTROL}, exp_control(1'b1, 1'b1));
    idle_cycles(20);
    write_reg({PAGE_COMMON, REG_FORMAT}, 32'h1);
    idle_cycles(20);
    write_reg({PAGE_COMMON, REG_FORMAT}, 32'h0);

    // constant on every lane
    const_val = sample_t'($random(seed));
    write_reg({PAGE_CHANNEL, REG_CONSTANT}, {16'd0, const_val});
    write_reg({PAGE_CHANNEL, REG_SOURCE}, {30'd0, SRC_CONST});
    idle_cycles(10);
    write_reg({PAGE_COMMON, REG_FORMAT}, 32'h1);
    idle_cycles(10);
    expect_reg("REG_CONSTANT", {PAGE_CHANNEL, REG_CONSTANT}, {16'd0, const_val});
    write_reg({PAGE_COMMON, REG_FORMAT}, 32'h0);

    // ramp with the step set before sync so the base starts clean
    step_val = step_t'($random(seed));
    write_reg({PAGE_CHANNEL, REG_STEP}, {16'd0, step_val});
    write_reg({PAGE_COMMON, REG_CONTROL}, 32'h7);
    write_reg({PAGE_CHANNEL, REG_SOURCE}, {30'd0, SRC_RAMP});
    idle_cycles(40);
    write_reg({PAGE_COMMON, REG_CONTROL}, 32'h7);
    idle_cycles(20);
    // unused code 3 behaves as dma
    write_reg({PAGE_CHANNEL, REG_SOURCE}, 32'h3);
    idle_cycles(10);
    expect_reg("REG_SOURCE", {PAGE_CHANNEL, REG_SOURCE}, 32'h3);
    write_reg({PAGE_CHANNEL, REG_SOURCE}, {30'd0, SRC_DMA});

    // sticky status flags
    ovf_seen = 1'b0;
    unf_seen = 1'b0;
    for (int i = 0; i < 16; i++) begin
      dac_dovf = 1'($random(seed));
      dac_dunf = 1'($random(seed));
      dac_status = 1'($random(seed));
      ovf_seen = ovf_seen | dac_dovf;
      unf_seen = unf_seen | dac_dunf;
      @(negedge up_clk);
    end
    dac_dovf = 1'b0;
    dac_dunf = 1'b0;
    expect_reg("REG_STATUS", {PAGE_COMMON, REG_STATUS},
      exp_status(ovf_seen, unf_seen, dac_status));
    write_reg({PAGE_COMMON, REG_STATUS}, 32'h3);
    expect_reg("REG_STATUS", {PAGE_COMMON, REG_STATUS}, exp_status(1'b0, 1'b0, dac_status));
    dac_dovf = 1'b1;
    @(negedge up_clk);
    dac_dovf = 1'b0;
    expect_reg("REG_STATUS", {PAGE_COMMON, REG_STATUS}, exp_status(1'b1, 1'b0, dac_status));
    dac_dunf = 1'b1;
    @(negedge up_clk);
    dac_dunf = 1'b0;
    dac_status = ~dac_status;
    expect_reg("REG_STATUS", {PAGE_COMMON, REG_STATUS}, exp_status(1'b1, 1'b1, dac_status));
    write_reg({PAGE_COMMON, REG_STATUS}, 32'h1);
    expect_reg("REG_STATUS", {PAGE_COMMON, REG_STATUS}, exp_status(1'b0, 1'b1, dac_status));
    write_reg({PAGE_COMMON, REG_STATUS}, 32'h2);
    expect_reg("REG_STATUS", {PAGE_COMMON, REG_STATUS}, exp_status(1'b0, 1'b0, dac_status));

    // output goes quiet on disable and on dac reset
    write_reg({PAGE_COMMON, REG_CONTROL}, 32'h1);
    compare_word(dac_data, '0);
    idle_cycles(5);
    write_reg({PAGE_COMMON, REG_CONTROL}, 32'h5);
    idle_cycles(5);
    write_reg({PAGE_COMMON, REG_CONTROL}, 32'h4);
    compare_word(dac_data, '0);
    idle_cycles(5);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verification
design/dac_regmap_pkg.sv
design/dac_sample_pkg.sv
design/dac_common_regs.sv
design/dac_channel_regs.sv
design/dac_pattern_gen.sv
design/dac_channel.sv
design/dac_core.sv
verification/dac_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module dac_core_tb -Mdir obj_dir

output="$(./obj_dir/Vdac_core_tb)"
echo "${output}"

if echo "${output}" | grep -qF "Done: no errors"; then
  exit 0
fi
exit 1
